// ==== Makefile ====
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_top_system -f compile.f -o sim_tb
	./obj_dir/sim_tb | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== compile.f ====
+incdir+hw
hw/uart_mon_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/byte_ram.sv
hw/cmd_engine.sv
hw/top_system.sv
verification/top_system_asserts.sv
verification/tb_top_system.sv

// ==== hw/byte_ram.sv ====
`timescale 1ns/1ps
`include "uart_mon_defs.svh"

module byte_ram (
   input  logic                  clk,
   input  uart_mon_pkg::ram_req_t ram_req,
   output logic [7:0]            rdata
);

   localparam int DEPTH = 1 << `MEM_AW;

   logic [7:0] mem [0:DEPTH-1];

   always_ff @(posedge clk) begin
      if (ram_req.we) begin
         mem[ram_req.addr] <= ram_req.wdata;
      end
      // read port follows the address every cycle
      rdata <= mem[ram_req.addr];
   end

endmodule

// ==== hw/cmd_engine.sv ====
`timescale 1ns/1ps
`include "uart_mon_defs.svh"

module cmd_engine (
   input  logic                   clk,
   input  logic                   rst,
   input  logic [7:0]             rx_data,
   input  logic                   rx_valid,
   output uart_mon_pkg::ram_req_t ram_req,
   input  logic [7:0]             rdata,
   input  logic                   tx_busy,
   output logic                   tx_start,
   output logic [7:0]             tx_data,
   output logic                   trap
);

   uart_mon_pkg::eng_state_e state;
   uart_mon_pkg::cmd_word_u  pend_cmd;
   uart_mon_pkg::cmd_word_u  act_cmd;

   logic [23:0]        frame_q;
   logic [1:0]         byte_cnt;
   logic               pend_valid;
   logic               take_byte;
   logic               launch;
   logic [`MEM_AW-1:0] run_addr;
   logic [7:0]         remaining;

   // bytes are dropped while a full frame waits
   assign take_byte = rx_valid && !pend_valid;
   assign launch    = (state == uart_mon_pkg::st_idle) && pend_valid;

   always_ff @(posedge clk) begin
      if (take_byte) begin
         frame_q <= {frame_q[15:0], rx_data};
         if (byte_cnt == 2'd3) begin
            pend_cmd <= {frame_q, rx_data};
         end
      end
      if (launch) begin
         act_cmd <= pend_cmd;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= uart_mon_pkg::st_idle;
         byte_cnt   <= 2'd0;
         pend_valid <= 1'b0;
         run_addr   <= '0;
         remaining  <= 8'd0;
         trap       <= 1'b0;
      end else begin
         if (take_byte) begin
            byte_cnt <= byte_cnt + 2'd1;
            if (byte_cnt == 2'd3) begin
               pend_valid <= 1'b1;
            end
         end
         if (launch) begin
            pend_valid <= 1'b0;
         end

         case (state)
            uart_mon_pkg::st_idle: begin
               if (pend_valid) begin
                  state <= uart_mon_pkg::st_decode;
               end
            end
            uart_mon_pkg::st_decode: begin
               case (act_cmd.wr.op)
                  `OP_WRITE: begin
                     run_addr <= act_cmd.wr.addr[`MEM_AW-1:0];
                     state    <= uart_mon_pkg::st_write_lo;
                  end
                  `OP_READ: begin
                     run_addr  <= act_cmd.rd.addr[`MEM_AW-1:0];
                     remaining <= act_cmd.rd.count;
                     // count zero sends nothing
                     state <= (act_cmd.rd.count == 8'd0) ? uart_mon_pkg::st_idle
                                                         : uart_mon_pkg::st_read_fetch;
                  end
                  default: begin
                     trap  <= 1'b1;
                     state <= uart_mon_pkg::st_idle;
                  end
               endcase
            end
            uart_mon_pkg::st_write_lo: begin
               run_addr <= run_addr + 1'b1;
               state    <= uart_mon_pkg::st_write_hi;
            end
            uart_mon_pkg::st_write_hi: begin
               state <= uart_mon_pkg::st_idle;
            end
            uart_mon_pkg::st_read_fetch: begin
               state <= uart_mon_pkg::st_read_send;
            end
            uart_mon_pkg::st_read_send: begin
               // address wraps at the top of memory
               run_addr  <= run_addr + 1'b1;
               remaining <= remaining - 8'd1;
               state     <= uart_mon_pkg::st_read_wait;
            end
            uart_mon_pkg::st_read_wait: begin
               if (!tx_busy) begin
                  state <= (remaining == 8'd0) ? uart_mon_pkg::st_idle
                                               : uart_mon_pkg::st_read_fetch;
               end
            end
            default: begin
               state <= uart_mon_pkg::st_idle;
            end
         endcase
      end
   end

   always_comb begin
      ram_req.we    = (state == uart_mon_pkg::st_write_lo) ||
                      (state == uart_mon_pkg::st_write_hi);
      ram_req.addr  = run_addr;
      ram_req.wdata = (state == uart_mon_pkg::st_write_hi) ? act_cmd.wr.data1
                                                           : act_cmd.wr.data0;
   end

   // memory data is valid the cycle after fetch
   assign tx_start = (state == uart_mon_pkg::st_read_send);
   assign tx_data  = rdata;

endmodule

// ==== hw/top_system.sv ====
`timescale 1ns/1ps

module top_system (
   input  logic clk,
   input  logic rst,

   // uart pins
   input  logic uart_rxd,
   output logic uart_txd,

   output logic trap
);

   logic [7:0]             rx_data;
   logic                   rx_valid;
   uart_mon_pkg::ram_req_t ram_req;
   logic [7:0]             rdata;
   logic                   tx_start;
   logic [7:0]             tx_data;
   logic                   tx_busy;

   uart_rx i_rx (
      .clk      (clk),
      .rst      (rst),
      .rxd      (uart_rxd),
      .rx_data  (rx_data),
      .rx_valid (rx_valid)
   );

   cmd_engine i_engine (
      .clk      (clk),
      .rst      (rst),
      .rx_data  (rx_data),
      .rx_valid (rx_valid),
      .ram_req  (ram_req),
      .rdata    (rdata),
      .tx_busy  (tx_busy),
      .tx_start (tx_start),
      .tx_data  (tx_data),
      .trap     (trap)
   );

   // local memory in place of external ddr
   byte_ram i_ram (
      .clk     (clk),
      .ram_req (ram_req),
      .rdata   (rdata)
   );

   uart_tx i_tx (
      .clk      (clk),
      .rst      (rst),
      .tx_start (tx_start),
      .tx_data  (tx_data),
      .txd      (uart_txd),
      .tx_busy  (tx_busy)
   );

endmodule

// ==== hw/uart_mon_defs.svh ====
`ifndef UART_MON_DEFS_SVH
`define UART_MON_DEFS_SVH

// clocks per serial bit, kept short for simulation
`define UART_DIV 8

// byte memory address width
`define MEM_AW 8

// command opcodes, ascii W and R
`define OP_WRITE 8'h57
`define OP_READ  8'h52

`endif

// ==== hw/uart_mon_pkg.sv ====
`include "uart_mon_defs.svh"

package uart_mon_pkg;

   // write frame, first received byte in the top byte
   typedef struct packed {
      logic [7:0] op;
      logic [7:0] addr;
      logic [7:0] data0;
      logic [7:0] data1;
   } wr_cmd_t;

   // read frame
   typedef struct packed {
      logic [7:0] op;
      logic [7:0] addr;
      logic [7:0] count;
      logic [7:0] pad;
   } rd_cmd_t;

   // one frame word, viewed by opcode
   typedef union packed {
      wr_cmd_t wr;
      rd_cmd_t rd;
   } cmd_word_u;

   typedef enum logic [2:0] {
      st_idle,
      st_decode,
      st_write_lo,
      st_write_hi,
      st_read_fetch,
      st_read_send,
      st_read_wait
   } eng_state_e;

   // engine to memory
   typedef struct packed {
      logic              we;
      logic [`MEM_AW-1:0] addr;
      logic [7:0]         wdata;
   } ram_req_t;

endpackage

// ==== hw/uart_rx.sv ====
`timescale 1ns/1ps
`include "uart_mon_defs.svh"

module uart_rx (
   input  logic       clk,
   input  logic       rst,
   input  logic       rxd,
   output logic [7:0] rx_data,
   output logic       rx_valid
);

   localparam int DIV  = `UART_DIV;
   localparam int HALF = `UART_DIV / 2;

   logic        rxd_meta;
   logic        rxd_s;
   logic        busy;
   logic [3:0]  bit_idx;
   logic [15:0] baud_cnt;
   logic [15:0] baud_end;
   logic        tick;
   logic [7:0]  shift_q;

   // start bit only waits half a period to land mid-bit
   assign baud_end = (bit_idx == 4'd0) ? 16'(HALF - 1) : 16'(DIV - 1);
   assign tick     = busy && (baud_cnt == baud_end);

   always_ff @(posedge clk) begin
      if (rst) begin
         rxd_meta <= 1'b1;
         rxd_s    <= 1'b1;
         busy     <= 1'b0;
         bit_idx  <= 4'd0;
         baud_cnt <= 16'd0;
         rx_valid <= 1'b0;
      end else begin
         rxd_meta <= rxd;
         rxd_s    <= rxd_meta;
         rx_valid <= 1'b0;
         if (!busy) begin
            // falling edge opens a frame
            if (!rxd_s) begin
               busy     <= 1'b1;
               bit_idx  <= 4'd0;
               baud_cnt <= 16'd0;
            end
         end else if (tick) begin
            baud_cnt <= 16'd0;
            if (bit_idx == 4'd0) begin
               // line back high at mid start, treat as glitch
               if (rxd_s) begin
                  busy <= 1'b0;
               end else begin
                  bit_idx <= 4'd1;
               end
            end else if (bit_idx <= 4'd8) begin
               bit_idx <= bit_idx + 4'd1;
            end else begin
               // stop bit, low means framing error
               busy     <= 1'b0;
               rx_valid <= rxd_s;
            end
         end else begin
            baud_cnt <= baud_cnt + 16'd1;
         end
      end
   end

   // data bits arrive lsb first
   always_ff @(posedge clk) begin
      if (tick && (bit_idx >= 4'd1) && (bit_idx <= 4'd8)) begin
         shift_q <= {rxd_s, shift_q[7:1]};
      end
   end

   assign rx_data = shift_q;

endmodule

// ==== hw/uart_tx.sv ====
`timescale 1ns/1ps
`include "uart_mon_defs.svh"

module uart_tx (
   input  logic       clk,
   input  logic       rst,
   input  logic       tx_start,
   input  logic [7:0] tx_data,
   output logic       txd,
   output logic       tx_busy
);

   localparam int DIV = `UART_DIV;

   logic [9:0]  frame_q;
   logic [3:0]  bit_cnt;
   logic [15:0] baud_cnt;

   always_ff @(posedge clk) begin
      if (rst) begin
         tx_busy  <= 1'b0;
         bit_cnt  <= 4'd0;
         baud_cnt <= 16'd0;
      end else if (!tx_busy) begin
         if (tx_start) begin
            tx_busy  <= 1'b1;
            bit_cnt  <= 4'd0;
            baud_cnt <= 16'd0;
         end
      end else if (baud_cnt == 16'(DIV - 1)) begin
         baud_cnt <= 16'd0;
         // ten bits out, start + 8 data + stop
         if (bit_cnt == 4'd9) begin
            tx_busy <= 1'b0;
         end else begin
            bit_cnt <= bit_cnt + 4'd1;
         end
      end else begin
         baud_cnt <= baud_cnt + 16'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (!tx_busy && tx_start) begin
         frame_q <= {1'b1, tx_data, 1'b0};
      end else if (tx_busy && (baud_cnt == 16'(DIV - 1))) begin
         frame_q <= {1'b1, frame_q[9:1]};
      end
   end

   // line idles high between frames
   assign txd = tx_busy ? frame_q[0] : 1'b1;

endmodule

// ==== verification/tb_top_system.sv ====
`timescale 1ns/1ps
`include "uart_mon_defs.svh"

module tb_top_system;

   localparam int DIV      = `UART_DIV;
   localparam int BYTE_CYC = 10 * `UART_DIV;

   // one line of the vector file
   typedef struct packed {
      logic        bad_stop;
      logic [31:0] frame;
      logic [7:0]  len;
      logic [63:0] exp;
      logic        trap;
   } vec_t;

   logic clk = 1'b0;
   logic rst;
   logic rxd;
   logic txd;
   logic trap;

   vec_t       vecs[$];
   logic [7:0] resp[$];
   int         errors = 0;
   bit         loaded = 1'b0;

   top_system i_dut (
      .clk      (clk),
      .rst      (rst),
      .uart_rxd (rxd),
      .uart_txd (txd),
      .trap     (trap)
   );

   always #4 clk = ~clk;

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   // 8N1 frame on rxd, stop bit level chosen by the caller
   task automatic send_byte(input logic [7:0] data, input logic stop, input int gap);
      logic [9:0] bits;
      int         i;
      bits = {stop, data, 1'b0};
      for (i = 0; i < 10; i++) begin
         rxd = bits[i];
         wait_cycles(DIV);
      end
      rxd = 1'b1;
      if (gap > 0) begin
         wait_cycles(gap * DIV);
      end
   endtask

   task automatic load_vectors();
      int    fd;
      int    n;
      int    fld [15];
      string line;
      vec_t  v;
      fd = $fopen("verification/uart_mon_vectors.txt", "r");
      if (fd == 0) begin
         $display("could not open the vector file verification/uart_mon_vectors.txt");
         errors++;
      end else begin
         while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line[0] != "#") begin
               n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                           fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                           fld[7], fld[8], fld[9], fld[10], fld[11], fld[12],
                           fld[13], fld[14]);
               if (n == 15) begin
                  v.bad_stop = fld[0][0];
                  v.frame    = {fld[1][7:0], fld[2][7:0], fld[3][7:0], fld[4][7:0]};
                  v.len      = fld[5][7:0];
                  v.exp      = {fld[6][7:0], fld[7][7:0], fld[8][7:0], fld[9][7:0],
                                fld[10][7:0], fld[11][7:0], fld[12][7:0], fld[13][7:0]};
                  v.trap     = fld[14][0];
                  vecs.push_back(v);
               end
            end
         end
         $fclose(fd);
         if (vecs.size() == 0) begin
            $display("the vector file holds no usable vectors");
            errors++;
         end
      end
      loaded = 1'b1;
   endtask

   task automatic run_vector(input int idx, input vec_t v);
      int limit;
      int cnt;
      int len;
      int k;
      len   = int'(v.len);
      limit = (len + 5) * BYTE_CYC;
      cnt   = 0;
      resp.delete();
      if (v.bad_stop) begin
         send_byte(8'h57, 1'b0, 1 + int'($urandom % 3));
      end
      for (k = 0; k < 4; k++) begin
         send_byte(v.frame[31 - 8*k -: 8], 1'b1, int'($urandom % 4));
      end
      // response bytes, or a bounded idle time
      while (resp.size() < len && cnt < limit) begin
         wait_cycles(1);
         cnt++;
      end
      // trailing quiet time exposes extra bytes
      wait_cycles(3 * BYTE_CYC);
      if (resp.size() < len) begin
         $display("vector %0d: response too short, %0d of %0d bytes",
                  idx, resp.size(), len);
         errors++;
      end else begin
         check_value($sformatf("vector %0d response length", idx),
                     32'(resp.size()), 32'(len));
      end
      for (k = 0; k < len && k < resp.size(); k++) begin
         check_value($sformatf("vector %0d uart_txd byte %0d", idx, k),
                     32'(resp[k]), 32'(v.exp[63 - 8*k -: 8]));
      end
      check_value($sformatf("vector %0d trap", idx), 32'(trap), 32'(v.trap));
   endtask

   // serial decoder on uart_txd, sampled mid-bit on the falling clock edge
   initial begin
      logic [7:0] shift;
      shift = 8'h00;
      forever begin
         @(negedge clk);
         if (txd === 1'b0 && rst === 1'b0) begin
            repeat (DIV / 2 - 1) @(negedge clk);
            if (txd === 1'b0) begin
               repeat (8) begin
                  repeat (DIV) @(negedge clk);
                  shift = {txd, shift[7:1]};
               end
               repeat (DIV) @(negedge clk);
               if (txd !== 1'b1) begin
                  $display("stop bit missing on uart_txd at %0t", $time);
                  errors++;
               end
               resp.push_back(shift);
            end
         end
      end
   end

   initial begin
      int i;
      rst = 1'b1;
      rxd = 1'b1;
      void'($urandom(32'hae7e));
      load_vectors();
      repeat (16) @(posedge clk);
      #1;
      rst = 1'b0;
      wait_cycles(4 * DIV);
      // line idles before any command
      check_value("uart_txd", 32'(txd), 32'd1);
      check_value("trap", 32'(trap), 32'd0);
      for (i = 0; i < vecs.size(); i++) begin
         run_vector(i, vecs[i]);
      end
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   // watchdog sized from the vector count
   initial begin
      longint limit_ns;
      wait (loaded);
      limit_ns = longint'(vecs.size() * 20 * BYTE_CYC + 50 * BYTE_CYC) * 8;
      #(limit_ns);
      $display("watchdog expired after %0d ns, the run did not complete", limit_ns);
      $display("errors: %0d", errors);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// ==== verification/top_system_asserts.sv ====
`timescale 1ns/1ps
`include "uart_mon_defs.svh"

module top_system_asserts (
   input logic                     clk,
   input logic                     rst,
   input logic                     tx_start,
   input logic                     tx_busy,
   input logic                     trap,
   input logic                     we,
   input logic [7:0]               op,
   input uart_mon_pkg::eng_state_e state
);

   // transmitter only takes a byte when idle
   a_start_idle: assert property (@(posedge clk) disable iff (rst)
      tx_start |-> !tx_busy)
      else $error("tx_start high while tx_busy is high");

   a_trap_sticky: assert property (@(posedge clk) disable iff (rst)
      $past(trap) |-> trap)
      else $error("trap fell while rst was low");

   // writes belong to a write command, low byte first, then high byte
   a_we_state: assert property (@(posedge clk) disable iff (rst)
      we |-> (op == `OP_WRITE) &&
             ((state == uart_mon_pkg::st_write_hi) == $past(we)))
      else $error("memory write outside the write pair of a write command");

endmodule

bind cmd_engine top_system_asserts i_asserts (
   .clk      (clk),
   .rst      (rst),
   .tx_start (tx_start),
   .tx_busy  (tx_busy),
   .trap     (trap),
   .we       (ram_req.we),
   .op       (act_cmd.wr.op),
   .state    (state)
);

// ==== verification/uart_mon_vectors.txt ====
# columns (hex): bad_stop op addr b2 b3 len e0 e1 e2 e3 e4 e5 e6 e7 trap
# bad_stop 1 sends one byte with a low stop bit ahead of the frame
0 57 10 a5 3c 0 00 00 00 00 00 00 00 00 0
0 52 10 02 00 2 a5 3c 00 00 00 00 00 00 0
# wrap across the top of memory
0 57 fe 11 22 0 00 00 00 00 00 00 00 00 0
0 57 00 33 44 0 00 00 00 00 00 00 00 00 0
0 52 fe 04 00 4 11 22 33 44 00 00 00 00 0
0 52 fe 00 00 0 00 00 00 00 00 00 00 00 0
# overwrite in the middle of a block
0 57 20 01 02 0 00 00 00 00 00 00 00 00 0
0 57 22 03 04 0 00 00 00 00 00 00 00 00 0
0 57 24 05 06 0 00 00 00 00 00 00 00 00 0
0 57 26 07 08 0 00 00 00 00 00 00 00 00 0
0 57 21 aa bb 0 00 00 00 00 00 00 00 00 0
0 52 20 08 00 8 01 aa bb 04 05 06 07 08 0
# unknown opcode, memory must stay as it was
0 58 10 ff ff 0 00 00 00 00 00 00 00 00 1
0 52 10 02 00 2 a5 3c 00 00 00 00 00 00 1
1 52 21 02 00 2 aa bb 00 00 00 00 00 00 1
